// File: tx_status_cfg.svh
// TX status reporting path, lane geometry and register map constants
`ifndef TX_STATUS_CFG_SVH
`define TX_STATUS_CFG_SVH

// Lane storage
`define TXS_NUM_LANES 4 // One lane per record word
`define TXS_DEPTH     64 // Entries per lane
`define TXS_CNT_W     7 // Holds 0..64

// Host register window
`define TXS_AXI_AW    7 // Byte address width of the read window

// Word index of lane 0, byte address 0x58
// Lanes 1..3 and status follow at consecutive words
`define TXS_REG_BASE  5'h16

`endif

// File: tx_status_pkg.sv
// TX status reporting path, shared record, register and response types
`default_nettype none

`include "tx_status_cfg.svh"

package tx_status_pkg;

    typedef logic [31:0] txs_word_t; // One host-visible status word

    // Four-word record as stored in the lanes, lane 0 first
    typedef struct packed {
        txs_word_t info; // {cw+slot msb, slot[8:0], prio, queue, 4'd0, bd idx, 1'd0, retry}
        txs_word_t ssn_word; // {14'd0, ssn, pkt_cnt}
        txs_word_t bmap_lo; // Block-ack bitmap 31:0
        txs_word_t bmap_hi; // Block-ack bitmap 63:32
    } txs_record_t;

    // Word indices of the read window, lanes then status
    typedef enum logic [4:0] {
        REG_INFO    = `TXS_REG_BASE,
        REG_SSN,
        REG_BMAP_LO,
        REG_BMAP_HI,
        REG_STATUS
    } txs_reg_e;

    // AXI read response codes in use
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } txs_resp_e;

    // Read channel FSM
    typedef enum logic {
        RD_IDLE, // Waiting for an address
        RD_RESP // Holding rdata until rready
    } txs_rd_state_e;

endpackage

`default_nettype wire

// File: tx_status_if.sv
// TX status reporting path, record and lane read-side interfaces
`timescale 1ns/1ns
`default_nettype none

`include "tx_status_cfg.svh"

// Capture to lane storage, one record per wr_en cycle, no back-pressure
interface tx_status_rec_if
    import tx_status_pkg::*;
();
    logic        wr_en; // Record valid this cycle
    txs_record_t data; // Packed report

    modport src (output wr_en, output data);
    modport dst (input  wr_en, input  data);
endinterface

// Lane storage to register reader
interface tx_status_rd_if
    import tx_status_pkg::*;
();
    txs_word_t [`TXS_NUM_LANES-1:0] head; // FWFT head of each lane
    logic [`TXS_NUM_LANES-1:0]      empty; // Per-lane empty flags
    logic [`TXS_CNT_W-1:0]          occ; // Lane 0 occupancy
    logic [`TXS_CNT_W-1:0]          drops; // Sticky dropped-report count
    logic [`TXS_NUM_LANES-1:0]      pop; // One-cycle pop per lane

    modport store  (output head, output empty, output occ, output drops, input pop);
    modport reader (input  head, input  empty, input  occ, input  drops, output pop);
endinterface

`default_nettype wire

// File: tx_status_capture.sv
// TX status capture stage, registers the completion strobe and packs the report
`timescale 1ns/1ns
`default_nettype none

module tx_status_capture
    import tx_status_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    input  logic        tx_try_complete, // One pulse per finished attempt
    input  logic [9:0]  num_slot_random,
    input  logic [3:0]  cw, // Contention window exponent
    input  logic [79:0] tx_status, // {bmap_hi, bmap_lo, ssn, retry}
    input  logic [1:0]  linux_prio,
    input  logic [5:0]  pkt_cnt,
    input  logic [1:0]  tx_queue_idx,
    input  logic [5:0]  bd_wr_idx,
    tx_status_rec_if.src rec
);

    // Raw status split
    logic [3:0]  num_retrans;
    logic [11:0] ssn;
    logic [31:0] bmap_lo;
    logic [31:0] bmap_hi;
    logic [3:0]  cw_field;

    assign num_retrans = tx_status[3:0];
    assign ssn         = tx_status[15:4];
    assign bmap_lo     = tx_status[47:16];
    assign bmap_hi     = tx_status[79:48];

    // Exponent plus slot msb, wraps in 4 bits like the driver expects
    assign cw_field = cw + {3'd0, num_slot_random[9]};

    // Strobe delay, lanes write one edge later
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rec.wr_en <= 1'b0;
        end else begin
            rec.wr_en <= tx_try_complete;
        end
    end

    // Payload only loads on a report, holds otherwise
    always_ff @(posedge clk) begin
        if (tx_try_complete) begin
            rec.data.info     <= {cw_field, num_slot_random[8:0], linux_prio, tx_queue_idx,
                                  4'd0, bd_wr_idx, 1'b0, num_retrans};
            rec.data.ssn_word <= {14'd0, ssn, pkt_cnt};
            rec.data.bmap_lo  <= bmap_lo;
            rec.data.bmap_hi  <= bmap_hi;
        end
    end

endmodule

`default_nettype wire

// File: tx_status_lanes.sv
// TX status lane storage, four 64-deep FWFT lanes sharing one write pointer
`timescale 1ns/1ns
`default_nettype none

`include "tx_status_cfg.svh"

module tx_status_lanes
    import tx_status_pkg::*;
(
    input  logic          clk,
    input  logic          rstn,
    tx_status_rec_if.dst  rec,
    tx_status_rd_if.store rd
);

    localparam int PTR_W = $clog2(`TXS_DEPTH); // Wraps naturally at depth

    txs_word_t [`TXS_NUM_LANES-1:0] din; // Record split per lane
    logic [PTR_W-1:0]      wr_ptr; // Common to all lanes
    logic [PTR_W-1:0]      rd_ptr [`TXS_NUM_LANES];
    logic [`TXS_CNT_W-1:0] cnt [`TXS_NUM_LANES]; // Per-lane occupancy
    logic [`TXS_NUM_LANES-1:0] empty;
    logic [`TXS_CNT_W-1:0] drops;
    logic                  full0; // Lane 0 full gates every write
    logic                  push;

    // Lane order matches the register map
    assign din[0] = rec.data.info;
    assign din[1] = rec.data.ssn_word;
    assign din[2] = rec.data.bmap_lo;
    assign din[3] = rec.data.bmap_hi;

    // Driver drains lane 0 last, so its count bounds the others
    assign full0 = (cnt[0] == `TXS_CNT_W'(`TXS_DEPTH));
    assign push  = rec.wr_en && !full0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
        end else if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
        end
    end

    // Sticky drop count, saturates instead of wrapping
    always_ff @(posedge clk) begin
        if (!rstn) begin
            drops <= '0;
        end else if (rec.wr_en && full0 && (drops != '1)) begin
            drops <= drops + 1'b1;
        end
    end

    for (genvar i = 0; i < `TXS_NUM_LANES; i++) begin : g_lane
        txs_word_t mem [`TXS_DEPTH]; // Inferred RAM, no reset
        logic      pop_ok;

        assign empty[i] = (cnt[i] == '0);
        assign pop_ok   = rd.pop[i] && !empty[i]; // Pop on empty is a no-op

        always_ff @(posedge clk) begin
            if (push) begin
                mem[wr_ptr] <= din[i];
            end
        end

        always_ff @(posedge clk) begin
            if (!rstn) begin
                rd_ptr[i] <= '0;
                cnt[i]    <= '0;
            end else begin
                if (pop_ok) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end
                case ({push, pop_ok})
                    2'b10:   cnt[i] <= cnt[i] + 1'b1;
                    2'b01:   cnt[i] <= cnt[i] - 1'b1;
                    default: cnt[i] <= cnt[i]; // Idle or push+pop
                endcase
            end
        end

        // FWFT, head is the entry under the read pointer
        assign rd.head[i] = mem[rd_ptr[i]];
    end

    assign rd.empty = empty;
    assign rd.occ   = cnt[0];
    assign rd.drops = drops;

endmodule

`default_nettype wire

// File: tx_status_regs.sv
// TX status register reader, AXI4-Lite read slave over the lane heads and status
`timescale 1ns/1ns
`default_nettype none

`include "tx_status_cfg.svh"

module tx_status_regs
    import tx_status_pkg::*;
(
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [`TXS_AXI_AW-1:0] araddr,
    input  logic                   arvalid,
    output logic                   arready,
    output txs_word_t              rdata,
    output txs_resp_e              rresp,
    output logic                   rvalid,
    input  logic                   rready,
    tx_status_rd_if.reader         rd
);

    txs_rd_state_e state;
    txs_reg_e      reg_idx; // Word index of the address
    txs_word_t     rd_word; // Decoded read data
    txs_resp_e     rd_resp;
    logic [`TXS_NUM_LANES-1:0] pop_sel; // Lane addressed, before handshake
    logic          ar_fire;

    assign reg_idx = txs_reg_e'(araddr[`TXS_AXI_AW-1:2]);
    assign ar_fire = arvalid && arready;

    // Address decode, misaligned and unmapped both give SLVERR with zero
    always_comb begin
        rd_word = '0;
        rd_resp = RESP_SLVERR;
        pop_sel = '0;
        if (araddr[1:0] == 2'b00) begin
            case (reg_idx)
                REG_INFO: begin
                    rd_word    = rd.empty[0] ? 32'hFFFF_FFFF : rd.head[0]; // Driver polls for ones
                    rd_resp    = RESP_OKAY;
                    pop_sel[0] = 1'b1;
                end
                REG_SSN: begin
                    rd_word    = rd.empty[1] ? 32'h0 : rd.head[1];
                    rd_resp    = RESP_OKAY;
                    pop_sel[1] = 1'b1;
                end
                REG_BMAP_LO: begin
                    rd_word    = rd.empty[2] ? 32'h0 : rd.head[2];
                    rd_resp    = RESP_OKAY;
                    pop_sel[2] = 1'b1;
                end
                REG_BMAP_HI: begin
                    rd_word    = rd.empty[3] ? 32'h0 : rd.head[3];
                    rd_resp    = RESP_OKAY;
                    pop_sel[3] = 1'b1;
                end
                REG_STATUS: begin
                    rd_word = {9'd0, rd.drops, 9'd0, rd.occ}; // Drops 22:16, occupancy 6:0
                    rd_resp = RESP_OKAY;
                end
                default: ; // Outside the window
            endcase
        end
    end

    // Pop lands on the accept edge, head advances for the next read
    assign rd.pop = ar_fire ? pop_sel : '0;

    // One outstanding read at most
    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= RD_IDLE;
        end else begin
            case (state)
                RD_IDLE: if (arvalid) state <= RD_RESP;
                RD_RESP: if (rready)  state <= RD_IDLE;
                default:              state <= RD_IDLE;
            endcase
        end
    end

    // Response payload sampled at accept, held under back-pressure
    always_ff @(posedge clk) begin
        if (ar_fire) begin
            rdata <= rd_word;
            rresp <= rd_resp;
        end
    end

    assign arready = (state == RD_IDLE);
    assign rvalid  = (state == RD_RESP);

endmodule

`default_nettype wire

// File: tx_status_top.sv
// TX status reporting top, capture, lane storage and AXI4-Lite read window
`timescale 1ns/1ns
`default_nettype none

module tx_status_top
    import tx_status_pkg::*;
(
    input  logic        clk,
    input  logic        rstn,
    // Report from the TX engine
    input  logic        tx_try_complete,
    input  logic [9:0]  num_slot_random,
    input  logic [3:0]  cw,
    input  logic [79:0] tx_status,
    input  logic [1:0]  linux_prio,
    input  logic [5:0]  pkt_cnt,
    input  logic [1:0]  tx_queue_idx,
    input  logic [5:0]  bd_wr_idx,
    // AXI4-Lite read channel
    input  logic [6:0]  araddr,
    input  logic        arvalid,
    output logic        arready,
    output logic [31:0] rdata,
    output logic [1:0]  rresp,
    output logic        rvalid,
    input  logic        rready
);

    tx_status_rec_if rec_if ();
    tx_status_rd_if  rd_if ();

    txs_resp_e resp; // Enum at the reader, plain bits outside

    // Stage 1
    tx_status_capture i_capture (
        .clk             (clk),
        .rstn            (rstn),
        .tx_try_complete (tx_try_complete),
        .num_slot_random (num_slot_random),
        .cw              (cw),
        .tx_status       (tx_status),
        .linux_prio      (linux_prio),
        .pkt_cnt         (pkt_cnt),
        .tx_queue_idx    (tx_queue_idx),
        .bd_wr_idx       (bd_wr_idx),
        .rec             (rec_if.src)
    );

    // Stage 2
    tx_status_lanes i_lanes (
        .clk  (clk),
        .rstn (rstn),
        .rec  (rec_if.dst),
        .rd   (rd_if.store)
    );

    // Stage 3
    tx_status_regs i_regs (
        .clk     (clk),
        .rstn    (rstn),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (resp),
        .rvalid  (rvalid),
        .rready  (rready),
        .rd      (rd_if.reader)
    );

    assign rresp = resp;

endmodule

`default_nettype wire

// File: tb_tx_status.sv
// TX status testbench reading random reports back over AXI4-Lite against a lane model
`timescale 1ns/1ns
`default_nettype none

`include "tx_status_cfg.svh"

module tb_tx_status
    import tx_status_pkg::*;
();
    localparam int TMO = 20; // Cycles allowed per handshake

    logic clk = 1'b0;
    logic rstn;
    logic tx_try_complete;
    logic [9:0] num_slot_random;
    logic [3:0] cw;
    logic [79:0] tx_status;
    logic [1:0] linux_prio;
    logic [5:0] pkt_cnt;
    logic [1:0] tx_queue_idx;
    logic [5:0] bd_wr_idx;
    logic [6:0] araddr;
    logic arvalid;
    logic arready;
    logic [31:0] rdata;
    logic [1:0] rresp;
    logic rvalid;
    logic rready;

    integer seed = 32'h6147;
    txs_word_t mdl [4][`TXS_DEPTH]; // Per-lane circular queue model
    int mdl_rd [4];
    int mdl_cnt [4];
    int mdl_drops = 0;
    txs_word_t exp_data [$]; // Expected responses in issue order
    txs_resp_e exp_resp [$];
    int n_issued = 0;
    int n_checked = 0;

    tx_status_top i_tx_status_top (.*);

    always #50 clk = ~clk;

    // Record layout from the driver's register map
    function automatic txs_record_t make_record(input logic [3:0] c, input logic [9:0] slot,
        input logic [79:0] st, input logic [1:0] prio, input logic [5:0] pkt,
        input logic [1:0] q, input logic [5:0] bd);
        txs_record_t r;
        r.info     = {c + {3'd0, slot[9]}, slot[8:0], prio, q, 4'd0, bd, 1'b0, st[3:0]};
        r.ssn_word = {14'd0, st[15:4], pkt};
        r.bmap_lo  = st[47:16];
        r.bmap_hi  = st[79:48];
        return r;
    endfunction

    task automatic check_word(input string name, input txs_word_t got, input txs_word_t exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic check_resp(input string name, input txs_resp_e got, input txs_resp_e exp);
        if (got !== exp) begin
            $display("MISMATCH %s: got %h expected %h", name, got, exp);
            $display("Regression failed");
            $fatal(1);
        end
    endtask

    task automatic abort(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1);
    endtask

    // One strobe cycle with the lane 0 cap kept in the model
    task automatic send_report(input logic [3:0] c, input logic [9:0] slot,
        input logic [79:0] st, input logic [1:0] prio, input logic [5:0] pkt,
        input logic [1:0] q, input logic [5:0] bd);
        txs_record_t rec;
        rec = make_record(c, slot, st, prio, pkt, q, bd);
        cw = c;
        num_slot_random = slot;
        tx_status = st;
        linux_prio = prio;
        pkt_cnt = pkt;
        tx_queue_idx = q;
        bd_wr_idx = bd;
        tx_try_complete = 1'b1;
        if (mdl_cnt[0] == `TXS_DEPTH) begin
            if (mdl_drops < 127) mdl_drops++; // Saturating like a 7-bit counter
        end else begin
            for (int l = 0; l < 4; l++) begin
                mdl[l][(mdl_rd[l] + mdl_cnt[l]) % `TXS_DEPTH] = rec[127 - 32*l -: 32];
                mdl_cnt[l]++;
            end
        end
        @(posedge clk);
        #10;
        tx_try_complete = 1'b0;
    endtask

    task automatic send_random(input logic force_msb);
        logic [31:0] r;
        logic [79:0] st;
        st[31:0] = $random(seed);
        st[63:32] = $random(seed);
        r = $random(seed);
        st[79:64] = r[15:0];
        r = $random(seed);
        send_report(r[3:0], {r[13] | force_msb, r[12:4]}, st, r[15:14], r[21:16],
                    r[23:22], r[29:24]);
    endtask

    // Expected word from the model where only a mapped lane read pops
    task automatic push_expect(input logic [6:0] addr);
        int idx;
        int lane;
        txs_word_t w;
        txs_resp_e r;
        idx = addr >> 2;
        lane = idx - `TXS_REG_BASE;
        w = '0;
        r = RESP_SLVERR;
        if (addr[1:0] == 2'b00 && lane >= 0 && lane < 4) begin
            r = RESP_OKAY;
            if (mdl_cnt[lane] == 0) begin
                w = (lane == 0) ? 32'hFFFF_FFFF : 32'h0; // Empty sentinels
            end else begin
                w = mdl[lane][mdl_rd[lane]];
                mdl_rd[lane] = (mdl_rd[lane] + 1) % `TXS_DEPTH;
                mdl_cnt[lane]--;
            end
        end else if (addr[1:0] == 2'b00 && lane == 4) begin
            r = RESP_OKAY;
            w = {9'd0, 7'(mdl_drops), 9'd0, 7'(mdl_cnt[0])};
        end
        exp_data.push_back(w);
        exp_resp.push_back(r);
        n_issued++;
    endtask

    // Single read with an optional rready hold and a blocked second address
    task automatic read_reg(input logic [6:0] addr, input int hold);
        int n;
        txs_word_t exp_word;
        push_expect(addr);
        exp_word = exp_data[exp_data.size() - 1]; // Model value for this read
        araddr = addr;
        arvalid = 1'b1;
        rready = (hold == 0);
        n = 0;
        @(negedge clk);
        while (!arready) begin
            n++;
            if (n > TMO) abort("Timeout waiting for arready");
            @(negedge clk);
        end
        @(posedge clk); // Accept edge
        #10;
        arvalid = 1'b0;
        n = 0;
        while (!rvalid) begin
            n++;
            if (n > TMO) abort("Timeout waiting for rvalid");
            @(negedge clk);
        end
        if (hold > 0) begin
            arvalid = 1'b1; // Must not be taken while the response waits
            araddr = 7'h58;
            repeat (hold) begin
                @(negedge clk);
                if (!rvalid) abort("rvalid dropped before rready");
                if (arready) abort("arready high while a response is pending");
                check_word("rdata held", rdata, exp_word);
            end
            @(posedge clk);
            #10;
            arvalid = 1'b0;
            rready = 1'b1;
        end
        n = 0;
        while (n_checked != n_issued) begin
            n++;
            if (n > TMO) abort("Timeout waiting for the rvalid/rready handshake");
            @(posedge clk);
            #10;
        end
    endtask

    task automatic drain_lane(input int lane, input int count);
        repeat (count + 1) read_reg(7'((`TXS_REG_BASE + lane) * 4), 0); // Last one hits empty
    endtask

    task automatic settle();
        repeat (2) @(posedge clk); // Report lands two edges after its strobe
        #10;
    endtask

    // Compare every completed read
    always @(posedge clk) begin
        if (rstn && rvalid && rready) begin
            if (exp_data.size() == 0) begin
                abort("Read response arrived with no read outstanding");
            end else begin
                check_word("rdata", rdata, exp_data.pop_front());
                check_resp("rresp", txs_resp_e'(rresp), exp_resp.pop_front());
                n_checked++;
            end
        end
    end

    initial begin
        int order [4];
        tx_try_complete = 1'b0;
        num_slot_random = '0;
        cw = '0;
        tx_status = '0;
        linux_prio = '0;
        pkt_cnt = '0;
        tx_queue_idx = '0;
        bd_wr_idx = '0;
        araddr = '0;
        arvalid = 1'b0;
        rready = 1'b0;
        rstn = 1'b0;
        for (int l = 0; l < 4; l++) begin
            mdl_rd[l] = 0;
            mdl_cnt[l] = 0;
        end
        repeat (2) @(posedge clk);
        #10;
        rstn = 1'b1;
        for (int a = 7'h58; a <= 7'h68; a += 4) read_reg(7'(a), 0); // Sentinels then zero status
        send_random(1'b1); // Slot msb set so the cw field gets the carry
        settle();
        for (int l = 0; l < 4; l++) drain_lane(l, 1);
        repeat (20) send_random(1'b0);
        settle();
        order = '{3, 1, 2, 0};
        foreach (order[k]) drain_lane(order[k], 20);
        repeat (70) send_random(1'b0); // Six past full
        settle();
        read_reg(7'h68, 0);
        order = '{2, 3, 1, 0};
        foreach (order[k]) drain_lane(order[k], 64);
        read_reg(7'h68, 0);
        repeat (3) send_random(1'b0);
        settle();
        for (int l = 1; l < 4; l++) read_reg(7'((`TXS_REG_BASE + l) * 4), 1 + ($random(seed) & 7));
        read_reg(7'h58, 1 + ($random(seed) & 7));
        drain_lane(1, 2);
        drain_lane(2, 2);
        drain_lane(3, 2);
        drain_lane(0, 2);
        send_random(1'b0);
        settle();
        read_reg(7'h00, 0); // Unmapped address leaves the lanes untouched
        read_reg(7'h6C, 0);
        for (int l = 0; l < 4; l++) drain_lane(l, 1);
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+.
tx_status_pkg.sv
tx_status_if.sv
tx_status_capture.sv
tx_status_lanes.sv
tx_status_regs.sv
tx_status_top.sv
tb_tx_status.sv

// File: Bender.yml
package:
  name: tx_status

sources:
  - include_dirs:
      - .
    files:
      - tx_status_pkg.sv
      - tx_status_if.sv
      - tx_status_capture.sv
      - tx_status_lanes.sv
      - tx_status_regs.sv
      - tx_status_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_tx_status.sv
